// File: bench/covox_tb.sv
`timescale 1ns/10ps

module covox_tb;

  import covox_pkg::*;

  // 60 transactions of ~200 cycles plus 20 dac windows of ~600 and a margin
  localparam int MAX_CYCLES    = (60 * 200 + 20 * 600) * 5 / 3;
  localparam int SAMPLE_PERIOD = 256;

  logic fclk;
  logic rst_n;
  logic spics_n;
  logic spick;
  logic spido;
  logic spidi;
  logic spiint_n;
  logic beep;
  logic clkz_out;

  integer seed       = 32'hb228;
  int     errors     = 0;
  int     tmo_cnt    = 0;
  logic   run_checks = 1'b0;

  // reference model state
  int          cyc;
  sample_t     m_mem [16];
  logic [3:0]  m_wr;
  logic [3:0]  m_rd;
  fifo_level_t m_level;
  sample_t     m_cur;
  sample_t     m_temp;
  logic        m_int_en;
  logic        exp_int_n;
  int          wr_req  = 0;
  int          wr_done = 0;
  spi_cmd_t    req_cmd;
  sample_t     req_data;

  covox_top covox_top_i (
    .fclk     (fclk),
    .rst_n    (rst_n),
    .spics_n  (spics_n),
    .spick    (spick),
    .spido    (spido),
    .spidi    (spidi),
    .spiint_n (spiint_n),
    .beep     (beep),
    .clkz_out (clkz_out)
  );

  always #50 fclk = ~fclk;

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------

  assign m_level = m_wr - m_rd;
  assign m_cur   = m_mem[m_rd];

  always @(posedge fclk)
  begin
    if (!rst_n)
    begin
      cyc       <= 0;
      m_wr      <= 4'd0;
      m_rd      <= 4'd0;
      m_int_en  <= 1'b0;
      exp_int_n <= 1'b1;
      for (int i = 0; i < 16; i++)
        m_mem[i] <= SAMPLE_RESET;
    end
    else
    begin
      cyc <= cyc + 1;
      // link write lands on the 4th edge after cs rises
      if (wr_req != wr_done)
      begin
        wr_done <= wr_req;
        case (req_cmd)
          cmd_temp_reg:
            m_temp <= req_data;
          cmd_covox:
          begin
            m_mem[m_wr + 4'd1] <= req_data;
            m_wr <= m_wr + 4'd1;
          end
          cmd_int_control:
            m_int_en <= req_data[0];
          default:
            ;
        endcase
      end
      // one pop per sample period unless empty
      if (cyc[7:0] == 8'hff && m_level != 4'd0)
        m_rd <= m_rd + 4'd1;
      exp_int_n <= m_int_en ? (m_level[3] | cyc[7]) : 1'b1;
    end
  end

  function automatic sample_t expected_read(input spi_cmd_t cmd);
    case (cmd)
      cmd_temp_reg:
        return m_temp;
      cmd_covox:
        return {4'h0, m_level};
      default:
        return READ_IDLE;
    endcase
  endfunction

  // ----------------------------------------------------------------------
  // compare tasks and monitors
  // ----------------------------------------------------------------------

  task automatic check_byte(input string name, input sample_t got, input sample_t exp);
    if (got !== exp)
    begin
      errors = errors + 1;
      $display("Error: %s = %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      errors = errors + 1;
      $display("Error: %s = %h, expected %h", name, got, exp);
    end
  endtask

  always @(negedge fclk)
  begin
    if (run_checks)
    begin
      check_bit("clkz_out", clkz_out, cyc[2]);
      check_bit("spiint_n", spiint_n, exp_int_n);
    end
  end

  always @(posedge fclk)
  begin
    tmo_cnt <= tmo_cnt + 1;
    if (tmo_cnt == MAX_CYCLES)
    begin
      $display("simulation hit the cycle limit of %0d before finishing", MAX_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // serial master
  // ----------------------------------------------------------------------

  // inputs change 5 ns after the edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge fclk);
    #5;
  endtask

  task automatic shift_byte(input sample_t tx, output sample_t rx);
    rx = 8'h00;
    for (int i = 7; i >= 0; i--)
    begin
      spick = 1'b0;
      spido = tx[i];
      wait_cycles(8);
      rx    = {rx[6:0], spidi};
      spick = 1'b1;
      wait_cycles(8);
    end
    spick = 1'b0;
    wait_cycles(8);
  endtask

  // send_cmd low keeps the last command byte in the link
  task automatic link_transfer(input spi_cmd_t cmd, input logic send_cmd,
                               input sample_t data, input logic check_rd,
                               output sample_t rd);
    sample_t dummy;
    sample_t exp_rd;
    if (send_cmd)
      shift_byte(sample_t'(cmd), dummy);
    spics_n = 1'b0;
    wait_cycles(3);
    exp_rd = expected_read(cmd);
    wait_cycles(5);
    shift_byte(data, rd);
    spics_n = 1'b1;
    wait_cycles(3);
    req_cmd  = cmd;
    req_data = data;
    wr_req   = wr_req + 1;
    wait_cycles(5);
    if (check_rd)
      check_byte("spidi read", rd, exp_rd);
  endtask

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------

  initial
  begin
    sample_t  rd;
    sample_t  s;
    spi_cmd_t op;
    int       n;
    int       cnt;
    int       pushes;
    logic     moved;
    fclk    = 1'b0;
    rst_n   = 1'b0;
    spics_n = 1'b1;
    spick   = 1'b0;
    spido   = 1'b0;
    wait_cycles(16);
    check_bit("spiint_n", spiint_n, 1'b1);
    check_bit("beep", beep, 1'b0);
    check_bit("spidi", spidi, 1'b1);
    check_bit("clkz_out", clkz_out, 1'b0);
    rst_n      = 1'b1;
    run_checks = 1'b1;

    // each temp register transfer reads back the previous byte
    link_transfer(cmd_temp_reg, 1'b1, sample_t'($random(seed)), 1'b0, rd);
    for (int i = 0; i < 10; i++)
      link_transfer(cmd_temp_reg, 1'b1, sample_t'($random(seed)), 1'b1, rd);

    // idle read-back
    link_transfer(cmd_int_control, 1'b1, 8'h00, 1'b1, rd);
    for (int i = 0; i < 4; i++)
    begin
      op = spi_cmd_t'(sample_t'($random(seed)));
      while (op == cmd_temp_reg || op == cmd_covox || op == cmd_int_control)
        op = spi_cmd_t'(sample_t'($random(seed)));
      link_transfer(op, 1'b1, sample_t'($random(seed)), 1'b1, rd);
    end

    // fifo level after a burst and after draining
    n = 1 + int'($unsigned($random(seed)) % 12);
    link_transfer(cmd_covox, 1'b1, sample_t'($random(seed)), 1'b1, rd);
    for (int i = 1; i < n; i++)
      link_transfer(cmd_covox, 1'b0, sample_t'($random(seed)), 1'b1, rd);
    link_transfer(cmd_covox, 1'b0, sample_t'($random(seed)), 1'b1, rd);
    wait_cycles(16 * SAMPLE_PERIOD);
    link_transfer(cmd_covox, 1'b0, sample_t'($random(seed)), 1'b1, rd);
    check_byte("fifo level", rd, 8'h00);

    // modulator density
    s = sample_t'($random(seed));
    link_transfer(cmd_covox, 1'b1, s, 1'b1, rd);
    for (int i = 1; i < 12; i++)
      link_transfer(cmd_covox, 1'b0, s, 1'b1, rd);
    while (m_cur != s)
      wait_cycles(1);
    cnt   = 0;
    moved = 1'b0;
    for (int i = 0; i < 512; i++)
    begin
      wait_cycles(1);
      if (beep)
        cnt = cnt + 1;
      if (m_cur != s)
        moved = 1'b1;
    end
    if (moved)
    begin
      errors = errors + 1;
      $display("the sample under test changed inside the density window");
    end
    if (cnt < 255 + int'(s) || cnt > 257 + int'(s))
    begin
      errors = errors + 1;
      $display("Error: beep high count = %h, expected %h", cnt, 256 + int'(s));
    end

    // interrupt checks run in the spiint_n monitor
    link_transfer(cmd_int_control, 1'b1, 8'h01, 1'b1, rd);
    link_transfer(cmd_covox, 1'b1, sample_t'($random(seed)), 1'b1, rd);
    pushes = 1;
    // from 10 entries the level stays at 8 or more over a whole low phase
    while (m_level < 4'd10 && pushes < 40)
    begin
      link_transfer(cmd_covox, 1'b0, sample_t'($random(seed)), 1'b1, rd);
      pushes = pushes + 1;
    end
    if (m_level < 4'd10)
    begin
      errors = errors + 1;
      $display("the fifo never reached 10 entries for the interrupt test");
    end
    while (m_level >= 4'd8)
      wait_cycles(1);
    wait_cycles(4 * SAMPLE_PERIOD);
    link_transfer(cmd_int_control, 1'b1, 8'h00, 1'b1, rd);
    wait_cycles(2 * SAMPLE_PERIOD);

    $display("errors: %0d", errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// File: hdl/avr_regs.sv
`timescale 1ns/10ps

module avr_regs
(
  input  logic                   fclk,
  input  logic                   rst_n,
  input  covox_pkg::spi_cmd_t    cmd_byte,
  input  covox_pkg::sample_t     wr_data,
  input  logic                   wr_strobe,
  input  logic                   rd_strobe,
  input  covox_pkg::fifo_level_t level,
  input  logic                   int_phase,
  output covox_pkg::sample_t     rd_data,
  output logic                   push_valid,
  output covox_pkg::sample_t     push_sample,
  output logic                   spiint_n
);

  import covox_pkg::*;

  sample_t temp_reg;
  logic    covox_int_en;

  // ----------------------------------------------------------------------
  // write side
  // ----------------------------------------------------------------------

  always_ff @(posedge fclk)
  begin
    if (wr_strobe && (cmd_byte == cmd_temp_reg))
      temp_reg <= wr_data;
  end

  always_ff @(posedge fclk)
  begin
    if (!rst_n)
    begin
      covox_int_en <= 1'b0;
      spiint_n     <= 1'b1;
    end
    else
    begin
      if (wr_strobe && (cmd_byte == cmd_int_control))
        covox_int_en <= wr_data[0];
      // asserted while the fifo runs low, gated by the phase
      if (covox_int_en)
        spiint_n <= level[3] | int_phase;
      else
        spiint_n <= 1'b1;
    end
  end

  // sample goes straight to the fifo
  assign push_valid  = wr_strobe && (cmd_byte == cmd_covox);
  assign push_sample = wr_data;

  // ----------------------------------------------------------------------
  // read side
  // ----------------------------------------------------------------------

  always_comb
  begin
    rd_data = READ_IDLE;
    if (rd_strobe)
    begin
      case (cmd_byte)
        cmd_temp_reg:
          rd_data = temp_reg;
        cmd_covox:
          rd_data = {4'h0, level};
        default:
          rd_data = READ_IDLE;
      endcase
    end
  end

endmodule

// File: hdl/avr_spi_link.sv
`timescale 1ns/10ps

module avr_spi_link
(
  input  logic                fclk,
  input  logic                rst_n,
  input  logic                spics_n,
  input  logic                spick,
  input  logic                spido,
  input  covox_pkg::sample_t  rd_data,
  output covox_pkg::spi_cmd_t cmd_byte,
  output covox_pkg::sample_t  wr_data,
  output logic                wr_strobe,
  output logic                rd_strobe,
  output logic                spidi
);

  import covox_pkg::*;

  logic [1:0] cs_sync;
  logic [1:0] ck_sync;
  logic [1:0] do_sync;
  logic       cs_prev;
  logic       ck_prev;
  logic       ck_rise;
  logic       ck_fall;
  logic [7:0] cmd_sr;
  logic [7:0] data_sr;
  sample_t    out_sr;
  logic [2:0] bit_ptr;

  // ----------------------------------------------------------------------
  // pin synchronizers and edge detect
  // ----------------------------------------------------------------------

  always_ff @(posedge fclk)
  begin
    if (!rst_n)
    begin
      cs_sync   <= 2'b11;
      cs_prev   <= 1'b1;
      ck_sync   <= 2'b00;
      ck_prev   <= 1'b0;
      do_sync   <= 2'b00;
      wr_strobe <= 1'b0;
      rd_strobe <= 1'b0;
    end
    else
    begin
      cs_sync   <= {cs_sync[0], spics_n};
      cs_prev   <= cs_sync[1];
      ck_sync   <= {ck_sync[0], spick};
      ck_prev   <= ck_sync[1];
      do_sync   <= {do_sync[0], spido};
      // cs high ends a write, cs low starts a read
      wr_strobe <= cs_sync[1] & ~cs_prev;
      rd_strobe <= ~cs_sync[1] & cs_prev;
    end
  end

  assign ck_rise = ck_sync[1] & ~ck_prev;
  assign ck_fall = ~ck_sync[1] & ck_prev;

  // ----------------------------------------------------------------------
  // shifters
  // ----------------------------------------------------------------------

  always_ff @(posedge fclk)
  begin
    if (!rst_n)
    begin
      cmd_sr  <= 8'hFF;
      data_sr <= 8'hFF;
      out_sr  <= READ_IDLE;
      bit_ptr <= 3'd7;
    end
    else
    begin
      if (ck_rise)
      begin
        if (cs_sync[1])
          cmd_sr <= {cmd_sr[6:0], do_sync[1]};
        else
          data_sr <= {data_sr[6:0], do_sync[1]};
      end
      if (rd_strobe)
        out_sr <= rd_data;
      // msb first, next bit after each falling spick
      if (cs_sync[1])
        bit_ptr <= 3'd7;
      else if (ck_fall)
        bit_ptr <= bit_ptr - 3'd1;
    end
  end

  assign cmd_byte = spi_cmd_t'(cmd_sr);
  assign wr_data  = data_sr;
  assign spidi    = out_sr[bit_ptr];

endmodule

// File: hdl/clock_div.sv
`timescale 1ns/10ps

module clock_div #(
  parameter int OSC_WIDTH = covox_pkg::OSC_WIDTH,
  parameter int RATE_LOG2 = 8
)(
  input  logic fclk,
  input  logic rst_n,
  output logic clkz_out,
  output logic sample_tick,
  output logic int_phase
);

  logic [OSC_WIDTH-1:0] osc_cnt;

  always_ff @(posedge fclk)
  begin
    if (!rst_n)
      osc_cnt <= '0;
    else
      osc_cnt <= osc_cnt + OSC_WIDTH'(1);
  end

  // fclk / 8 for the z80
  assign clkz_out = osc_cnt[2];

  // last cycle of every sample period
  assign sample_tick = &osc_cnt[RATE_LOG2-1:0];

  // half a sample period high, half low
  assign int_phase = osc_cnt[RATE_LOG2-1];

endmodule

// File: hdl/covox_dac.sv
`timescale 1ns/10ps

module covox_dac
(
  input  logic               fclk,
  input  logic               rst_n,
  input  covox_pkg::sample_t cur_sample,
  output logic               beep
);

  logic [8:0] acc;
  logic [9:0] sum;

  // first order sigma-delta, step is 256 + sample out of 512
  assign sum = {1'b0, acc} + {1'b0, 1'b1, cur_sample};

  always_ff @(posedge fclk)
  begin
    if (!rst_n)
    begin
      acc  <= 9'd0;
      beep <= 1'b0;
    end
    else
    begin
      acc  <= sum[8:0];
      // carry out is the pulse density stream
      beep <= sum[9];
    end
  end

endmodule

// File: hdl/covox_fifo.sv
`timescale 1ns/10ps

module covox_fifo #(
  parameter int FIFO_DEPTH_LOG2 = 4
)(
  input  logic                   fclk,
  input  logic                   rst_n,
  input  logic                   push_valid,
  input  covox_pkg::sample_t     push_sample,
  input  logic                   sample_tick,
  output covox_pkg::sample_t     cur_sample,
  output covox_pkg::fifo_level_t level
);

  import covox_pkg::*;

  localparam int DEPTH = 2 ** FIFO_DEPTH_LOG2;

  sample_t                    mem [DEPTH];
  logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
  logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
  logic [FIFO_DEPTH_LOG2-1:0] wr_next;

  // write lands one past the pointer, then the pointer moves onto it
  assign wr_next = wr_ptr + FIFO_DEPTH_LOG2'(1);

  always_ff @(posedge fclk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < DEPTH; i++)
        mem[i] <= SAMPLE_RESET;
    end
    else if (push_valid)
      mem[wr_next] <= push_sample;
  end

  always_ff @(posedge fclk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      // full push overwrites, level wraps
      if (push_valid)
        wr_ptr <= wr_next;
      if (sample_tick && (level != '0))
        rd_ptr <= rd_ptr + FIFO_DEPTH_LOG2'(1);
    end
  end

  assign level      = fifo_level_t'(wr_ptr - rd_ptr);
  assign cur_sample = mem[rd_ptr];

endmodule

// File: hdl/covox_pkg.sv
package covox_pkg;

  // ----------------------------------------------------------------------
  // host link opcodes
  // ----------------------------------------------------------------------

  // anything else on the link is an unused command
  typedef enum logic [7:0] {
    cmd_temp_reg    = 8'hA0,
    cmd_covox       = 8'h53,
    cmd_int_control = 8'h54
  } spi_cmd_t;

  // ----------------------------------------------------------------------
  // audio path types
  // ----------------------------------------------------------------------

  // unsigned, 8'h80 is mid scale
  typedef logic [7:0] sample_t;

  // write pointer minus read pointer, modulo 16
  typedef logic [3:0] fifo_level_t;

  // near mid scale so the beeper idles quietly
  localparam sample_t SAMPLE_RESET = 8'h7F;

  // read-back byte for commands with nothing to return
  localparam sample_t READ_IDLE = 8'hFF;

  // free-running divider width
  localparam int OSC_WIDTH = 10;

endpackage

// File: hdl/covox_top.sv
`timescale 1ns/10ps

module covox_top #(
  parameter int FIFO_DEPTH_LOG2 = 4,
  parameter int RATE_LOG2       = 8
)(
  input  logic fclk,
  input  logic rst_n,
  input  logic spics_n,
  input  logic spick,
  input  logic spido,
  output logic spidi,
  output logic spiint_n,
  output logic beep,
  output logic clkz_out
);

  import covox_pkg::*;

  logic        sample_tick;
  logic        int_phase;
  spi_cmd_t    cmd_byte;
  sample_t     wr_data;
  logic        wr_strobe;
  logic        rd_strobe;
  sample_t     rd_data;
  logic        push_valid;
  sample_t     push_sample;
  sample_t     cur_sample;
  fifo_level_t level;

  // ----------------------------------------------------------------------
  // timing and host link
  // ----------------------------------------------------------------------

  clock_div #(
    .OSC_WIDTH   (OSC_WIDTH),
    .RATE_LOG2   (RATE_LOG2)
  ) clock_div_i (
    .fclk        (fclk),
    .rst_n       (rst_n),
    .clkz_out    (clkz_out),
    .sample_tick (sample_tick),
    .int_phase   (int_phase)
  );

  avr_spi_link avr_spi_link_i (
    .fclk      (fclk),
    .rst_n     (rst_n),
    .spics_n   (spics_n),
    .spick     (spick),
    .spido     (spido),
    .rd_data   (rd_data),
    .cmd_byte  (cmd_byte),
    .wr_data   (wr_data),
    .wr_strobe (wr_strobe),
    .rd_strobe (rd_strobe),
    .spidi     (spidi)
  );

  avr_regs avr_regs_i (
    .fclk        (fclk),
    .rst_n       (rst_n),
    .cmd_byte    (cmd_byte),
    .wr_data     (wr_data),
    .wr_strobe   (wr_strobe),
    .rd_strobe   (rd_strobe),
    .level       (level),
    .int_phase   (int_phase),
    .rd_data     (rd_data),
    .push_valid  (push_valid),
    .push_sample (push_sample),
    .spiint_n    (spiint_n)
  );

  // ----------------------------------------------------------------------
  // audio path
  // ----------------------------------------------------------------------

  covox_fifo #(
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
  ) covox_fifo_i (
    .fclk        (fclk),
    .rst_n       (rst_n),
    .push_valid  (push_valid),
    .push_sample (push_sample),
    .sample_tick (sample_tick),
    .cur_sample  (cur_sample),
    .level       (level)
  );

  covox_dac covox_dac_i (
    .fclk       (fclk),
    .rst_n      (rst_n),
    .cur_sample (cur_sample),
    .beep       (beep)
  );

endmodule

// File: run.sh
#!/bin/bash
# build and run the covox testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module covox_tb -o covox_sim \
  && ./obj_dir/covox_sim | tee /dev/stderr | grep -q "Regression passed" \
  && echo "simulation ok" \
  || { echo "simulation FAILED"; exit 1; }

// File: verilog.f
hdl/covox_pkg.sv
hdl/clock_div.sv
hdl/avr_spi_link.sv
hdl/avr_regs.sv
hdl/covox_fifo.sv
hdl/covox_dac.sv
hdl/covox_top.sv
bench/covox_tb.sv
